//--- esc_pkg.sv
`default_nettype none

package esc_pkg;

  localparam int data_w      = 16;  // periods, duty, pid datapath
  localparam int gain_w      = 8;   // kp and ki
  localparam int kd_w        = 7;
  localparam int axil_addr_w = 8;
  localparam int axil_data_w = 32;

  localparam logic [axil_addr_w-1:0] reg_pwm_period  = 8'h00;
  localparam logic [axil_addr_w-1:0] reg_period_ref  = 8'h04;
  localparam logic [axil_addr_w-1:0] reg_gains       = 8'h08;  // kp, ki, control byte
  localparam logic [axil_addr_w-1:0] reg_meas_period = 8'h10;  // read only
  localparam logic [axil_addr_w-1:0] reg_duty        = 8'h14;  // read only
  localparam logic [axil_addr_w-1:0] reg_kp_active   = 8'h18;  // read only

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  localparam int integ_limit = 2047;  // integral saturation bound

  // quadrature steps, written as {a,b} previous -> current
  // forward (a leads b): 00->10, 10->11, 11->01, 01->00
  // reverse (b leads a): 00->01, 01->11, 11->10, 10->00
  // anything else keeps the last direction
  typedef enum logic [1:0] {dir_none, dir_fwd, dir_rev} dir_t;

  typedef union packed {
    logic [7:0] raw;                   // as written by the host
    struct packed {
      logic            override;       // take gains from registers
      logic [kd_w-1:0] kd;
    } fields;
  } ctrl_byte_u;

  typedef struct packed {
    logic [data_w-1:0] pwm_period;
    logic [data_w-1:0] period_ref;
    logic [gain_w-1:0] kp;
    logic [gain_w-1:0] ki;
    ctrl_byte_u        ctrl_byte;
  } esc_cfg_t;

  typedef struct packed {
    logic tick;
    logic enc_a;
    logic enc_b;
    logic pwm_en;
  } sync_t;

  typedef struct packed {
    logic              tick;
    logic [data_w-1:0] meas_period;
    dir_t              dir;
    logic              pwm_en;
  } speed_t;

  typedef struct packed {
    logic              tick;
    logic [data_w-1:0] duty;
    dir_t              dir;
    logic              pwm_en;
    logic [gain_w-1:0] kp_active;
  } ctrl_t;

endpackage

`default_nettype wire

//--- esc_axil_regs.sv
`default_nettype none

module esc_axil_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [esc_pkg::axil_addr_w-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [esc_pkg::axil_data_w-1:0]   wdata,
  input  logic [esc_pkg::axil_data_w/8-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [esc_pkg::axil_addr_w-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [esc_pkg::axil_data_w-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  output esc_pkg::esc_cfg_t                 cfg,
  input  logic [esc_pkg::data_w-1:0]        meas_period,
  input  logic [esc_pkg::data_w-1:0]        duty,
  input  logic [esc_pkg::gain_w-1:0]        kp_active
);
  import esc_pkg::*;

  logic                   resp_busy;
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   wr_err;
  logic                   rd_err;
  logic [axil_data_w-1:0] rd_word;

  assign resp_busy = bvalid || rvalid;  // hold off new addresses
  assign wr_hs     = awready && awvalid && wvalid;
  assign rd_hs     = arready && arvalid;

  always_comb begin
    case (awaddr)
      reg_pwm_period, reg_period_ref, reg_gains,
      reg_meas_period, reg_duty, reg_kp_active: wr_err = 1'b0;  // status writes ignored
      default:                                  wr_err = 1'b1;
    endcase
  end

  always_comb begin
    rd_err = 1'b0;
    case (araddr)
      reg_pwm_period:  rd_word = {16'b0, cfg.pwm_period};
      reg_period_ref:  rd_word = {16'b0, cfg.period_ref};
      reg_gains:       rd_word = {8'b0, cfg.ctrl_byte.raw, cfg.ki, cfg.kp};
      reg_meas_period: rd_word = {16'b0, meas_period};
      reg_duty:        rd_word = {16'b0, duty};
      reg_kp_active:   rd_word = {24'b0, kp_active};
      default: begin
        rd_word = '0;
        rd_err  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= resp_okay;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rresp   <= resp_okay;
    end else begin
      awready <= awvalid && wvalid && !awready && !resp_busy;  // one-cycle pulse
      wready  <= awvalid && wvalid && !awready && !resp_busy;
      arready <= arvalid && !arready && !resp_busy;
      if (wr_hs) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? resp_slverr : resp_okay;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_hs) begin
        rvalid <= 1'b1;
        rresp  <= rd_err ? resp_slverr : resp_okay;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rdata <= rd_word;
    end
  end

  // byte lanes follow wstrb
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr_hs) begin
      case (awaddr)
        reg_pwm_period: begin
          if (wstrb[0]) cfg.pwm_period[7:0]  <= wdata[7:0];
          if (wstrb[1]) cfg.pwm_period[15:8] <= wdata[15:8];
        end
        reg_period_ref: begin
          if (wstrb[0]) cfg.period_ref[7:0]  <= wdata[7:0];
          if (wstrb[1]) cfg.period_ref[15:8] <= wdata[15:8];
        end
        reg_gains: begin
          if (wstrb[0]) cfg.kp            <= wdata[7:0];
          if (wstrb[1]) cfg.ki            <= wdata[15:8];
          if (wstrb[2]) cfg.ctrl_byte.raw <= wdata[23:16];
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- esc_input_sync.sv
`default_nettype none

module esc_input_sync #(
  parameter int tick_div = 64,
  parameter int debounce = 3
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           encoder_a,
  input  logic           encoder_b,
  input  logic           pwm_en,
  output esc_pkg::sync_t sync
);
  import esc_pkg::*;

  localparam int n_in  = 3;  // a, b, pwm_en
  localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [cnt_w-1:0]    div_cnt;
  logic                tick_now;
  logic                tick_q;
  logic [n_in-1:0]     raw_meta;
  logic [n_in-1:0]     raw_s;
  logic [debounce-1:0] shift [n_in];
  logic [n_in-1:0]     level;

  assign tick_now = (div_cnt == cnt_w'(tick_div - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt  <= '0;
      tick_q   <= 1'b0;
      raw_meta <= '0;
      raw_s    <= '0;
      level    <= '0;
      for (int i = 0; i < n_in; i++) begin
        shift[i] <= '0;
      end
    end else begin
      raw_meta <= {encoder_a, encoder_b, pwm_en};  // async inputs
      raw_s    <= raw_meta;
      tick_q   <= tick_now;
      div_cnt  <= tick_now ? '0 : div_cnt + 1'b1;
      if (tick_now) begin
        for (int i = 0; i < n_in; i++) begin
          shift[i] <= {shift[i][debounce-2:0], raw_s[i]};
          if (shift[i] == '0 || shift[i] == '1) begin
            level[i] <= shift[i][0];  // all samples agree
          end
        end
      end
    end
  end

  assign sync.tick   = tick_q;
  assign sync.enc_a  = level[2];
  assign sync.enc_b  = level[1];
  assign sync.pwm_en = level[0];

endmodule

`default_nettype wire

//--- esc_speed_meter.sv
`default_nettype none

module esc_speed_meter (
  input  logic            clk,
  input  logic            reset,
  input  esc_pkg::sync_t  sync,
  output esc_pkg::speed_t speed
);
  import esc_pkg::*;

  typedef enum logic [1:0] {ph_idle, ph_high, ph_low} phase_t;

  phase_t            phase;
  logic [data_w-1:0] tick_cnt;
  logic [1:0]        ab_prev;
  logic [1:0]        ab_cur;
  dir_t              dir_next;

  assign ab_cur = {sync.enc_a, sync.enc_b};

  always_comb begin
    case ({ab_prev, ab_cur})
      4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: dir_next = dir_fwd;  // a leads
      4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: dir_next = dir_rev;  // b leads
      default:                                dir_next = speed.dir;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase    <= ph_idle;
      tick_cnt <= '0;
      ab_prev  <= '0;
      speed    <= '0;
    end else begin
      speed.tick   <= sync.tick;
      speed.pwm_en <= sync.pwm_en;
      if (sync.tick) begin
        ab_prev <= ab_cur;
        if (sync.pwm_en) speed.dir <= dir_next;
        if (phase != ph_idle && tick_cnt != '1) tick_cnt <= tick_cnt + 1'b1;  // saturates
        case (phase)
          ph_idle: if (sync.enc_a) begin  // first rising edge
            tick_cnt <= data_w'(1);
            phase    <= ph_high;
          end
          ph_high: if (!sync.enc_a) phase <= ph_low;
          default: if (sync.enc_a) begin
            speed.meas_period <= tick_cnt;  // one full a period
            tick_cnt          <= data_w'(1);
            phase             <= ph_high;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- esc_pid.sv
`default_nettype none

module esc_pid (
  input  logic              clk,
  input  logic              reset,
  input  esc_pkg::esc_cfg_t cfg,
  input  esc_pkg::speed_t   speed,
  output esc_pkg::ctrl_t    ctrl
);
  import esc_pkg::*;

  logic        [gain_w-1:0] kp_sel;
  logic        [gain_w-1:0] ki_sel;
  logic        [kd_w-1:0]   kd_sel;
  logic signed [data_w:0]   error;
  logic signed [data_w:0]   prev_error;
  logic signed [data_w-1:0] integral;
  logic signed [data_w-1:0] integ_next;
  logic signed [data_w+1:0] integ_sum;
  logic signed [data_w+1:0] deriv;
  logic signed [31:0]       p_term;
  logic signed [31:0]       i_term;
  logic signed [31:0]       d_term;
  logic signed [31:0]       pid;
  logic        [data_w-1:0] duty_next;

  always_comb begin
    if (cfg.ctrl_byte.fields.override) begin
      kp_sel = cfg.kp;
      ki_sel = cfg.ki;
      kd_sel = cfg.ctrl_byte.fields.kd;
    end else begin
      kp_sel = gain_w'(1);  // p-only fallback
      ki_sel = '0;
      kd_sel = '0;
    end
  end

  assign error     = $signed({1'b0, cfg.period_ref}) - $signed({1'b0, speed.meas_period});
  assign integ_sum = integral + error;
  assign deriv     = error - prev_error;

  always_comb begin
    if (integ_sum > integ_limit) begin
      integ_next = data_w'(integ_limit);
    end else if (integ_sum < -integ_limit) begin
      integ_next = data_w'(-integ_limit);
    end else begin
      integ_next = integ_sum[data_w-1:0];
    end
  end

  assign p_term = $signed({1'b0, kp_sel}) * error;
  assign i_term = ($signed({1'b0, ki_sel}) * integ_next) >>> 3;
  assign d_term = $signed({1'b0, kd_sel}) * deriv;
  assign pid    = p_term + i_term + d_term;

  // clamp into the pwm range
  always_comb begin
    if (pid < 1) begin
      duty_next = cfg.pwm_period;
    end else if (pid > $signed({16'b0, cfg.pwm_period})) begin
      duty_next = cfg.pwm_period >> 2;
    end else begin
      duty_next = pid[data_w-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      integral   <= '0;
      prev_error <= '0;
      ctrl       <= '0;
    end else begin
      ctrl.tick   <= speed.tick;
      ctrl.dir    <= speed.dir;
      ctrl.pwm_en <= speed.pwm_en;
      if (speed.tick) begin
        integral       <= integ_next;
        prev_error     <= error;
        ctrl.duty      <= duty_next;
        ctrl.kp_active <= kp_sel;  // gains in use this tick
      end
    end
  end

endmodule

`default_nettype wire

//--- esc_pwm_drive.sv
`default_nettype none

module esc_pwm_drive (
  input  logic              clk,
  input  logic              reset,
  input  esc_pkg::esc_cfg_t cfg,
  input  esc_pkg::ctrl_t    ctrl,
  output logic              motor_positive,
  output logic              motor_negative
);
  import esc_pkg::*;

  logic [data_w-1:0] pwm_cnt;
  logic              pwm_bit;
  logic              drive_on;
  logic              pos_next;
  logic              neg_next;

  assign drive_on = ctrl.pwm_en && (cfg.pwm_period != '0);

  // steer the pwm bit onto one half of the bridge
  always_comb begin
    pos_next = 1'b0;
    neg_next = 1'b0;
    if (drive_on) begin
      case (ctrl.dir)
        dir_fwd: pos_next = pwm_bit;
        dir_rev: neg_next = pwm_bit;
        default: begin
          if (cfg.period_ref[data_w-1]) begin  // negative reference
            neg_next = pwm_bit;
          end else begin
            pos_next = pwm_bit;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pwm_cnt        <= '0;
      pwm_bit        <= 1'b0;
      motor_positive <= 1'b0;
      motor_negative <= 1'b0;
    end else if (ctrl.tick) begin
      if (pwm_cnt >= cfg.pwm_period) begin
        pwm_cnt <= '0;  // wrap, also if period shrank
      end else begin
        pwm_cnt <= pwm_cnt + 1'b1;
      end
      pwm_bit        <= (pwm_cnt < ctrl.duty);
      motor_positive <= pos_next;
      motor_negative <= neg_next;
    end
  end

endmodule

`default_nettype wire

//--- esc_top.sv
`default_nettype none

module esc_top #(
  parameter int tick_div = 64,
  parameter int debounce = 3
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [esc_pkg::axil_addr_w-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [esc_pkg::axil_data_w-1:0]   wdata,
  input  logic [esc_pkg::axil_data_w/8-1:0] wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [esc_pkg::axil_addr_w-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [esc_pkg::axil_data_w-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  input  logic                              encoder_a,
  input  logic                              encoder_b,
  input  logic                              pwm_en,
  output logic                              motor_positive,
  output logic                              motor_negative
);
  import esc_pkg::*;

  esc_cfg_t cfg;
  sync_t    sync;
  speed_t   speed;
  ctrl_t    ctrl;

  esc_axil_regs regs_i (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .cfg,
    .meas_period (speed.meas_period),
    .duty        (ctrl.duty),
    .kp_active   (ctrl.kp_active)
  );

  esc_input_sync #(
    .tick_div (tick_div),
    .debounce (debounce)
  ) sync_i (
    .clk, .reset, .encoder_a, .encoder_b, .pwm_en, .sync
  );

  esc_speed_meter speed_i (.clk, .reset, .sync, .speed);

  esc_pid pid_i (.clk, .reset, .cfg, .speed, .ctrl);

  esc_pwm_drive drive_i (.clk, .reset, .cfg, .ctrl, .motor_positive, .motor_negative);

endmodule

`default_nettype wire

//--- tb_esc_checks.svh
`ifndef tb_esc_checks_svh
`define tb_esc_checks_svh

task automatic check_data(input string name, input logic [axil_data_w-1:0] got,
                          input logic [axil_data_w-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
  end
endtask

task automatic check_motor(input string name, input motor_pair_t got, input motor_pair_t exp);
  if (got !== exp) begin
    abort_run($sformatf("Mismatch at %0t ns: %s got pos=%b neg=%b expected pos=%b neg=%b",
                        $time, name, got.pos, got.neg, exp.pos, exp.neg));
  end
endtask

// address and data presented together, each valid drops on its own ready
task automatic axi_write(input logic [axil_addr_w-1:0] addr, input logic [axil_data_w-1:0] data,
                         output logic [1:0] resp);
  logic aw_done;
  logic w_done;
  @(posedge clk);
  #2;
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = '1;
  wvalid  = 1'b1;
  aw_done = 1'b0;
  w_done  = 1'b0;
  while (!(aw_done && w_done)) begin
    @(posedge clk);
    if (awready) aw_done = 1'b1;
    if (wready) w_done = 1'b1;
    #2;
    if (aw_done) awvalid = 1'b0;
    if (w_done) wvalid = 1'b0;
  end
  bready = 1'b1;
  @(posedge clk);
  while (!bvalid) @(posedge clk);
  resp = bresp;
  #2;
  bready = 1'b0;
endtask

task automatic axi_read(input logic [axil_addr_w-1:0] addr, output logic [axil_data_w-1:0] data,
                        output logic [1:0] resp);
  @(posedge clk);
  #2;
  araddr  = addr;
  arvalid = 1'b1;
  @(posedge clk);
  while (!arready) @(posedge clk);
  #2;
  arvalid = 1'b0;
  rready  = 1'b1;
  @(posedge clk);
  while (!rvalid) @(posedge clk);
  data = rdata;
  resp = rresp;
  #2;
  rready = 1'b0;
endtask

`endif

//--- tb_esc.sv
`default_nettype none

module tb_esc;
  timeunit 1ns;
  timeprecision 100ps;
  import esc_pkg::*;

  localparam int clk_period = 20;
  localparam int tick_div   = 8;  // short tick keeps runs brief
  localparam int debounce   = 3;

  typedef struct packed {
    logic pos;
    logic neg;
  } motor_pair_t;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
  } rec_t;

  logic                     clk;
  logic                     reset;
  logic [axil_addr_w-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [axil_data_w-1:0]   wdata;
  logic [axil_data_w/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [axil_addr_w-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [axil_data_w-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     encoder_a;
  logic                     encoder_b;
  logic                     pwm_en;
  logic                     motor_positive;
  logic                     motor_negative;

  rec_t        recs[$];
  longint      limit_ns  = 0;
  logic [31:0] rng_state = 32'hac89_fafb;
  int          pos_count = 0;  // clocks with a bridge half on
  int          neg_count = 0;
  int          pos_base  = 0;
  int          neg_base  = 0;

  esc_top #(
    .tick_div (tick_div),
    .debounce (debounce)
  ) esc_top_i (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .encoder_a, .encoder_b, .pwm_en, .motor_positive, .motor_negative
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  `include "tb_esc_checks.svh"

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // worst case duration of one record in ns
  function automatic longint record_cost(input rec_t r);
    longint tick_ns;
    tick_ns = tick_div * clk_period;
    case (r.op)
      "X":     return longint'(r.a) * 6 * 2000;  // write and read per register
      "E":     return (longint'(r.b) + 1) * r.a * tick_ns + 2000;
      "T":     return longint'(r.a) * tick_ns + 2000;
      default: return 2000;
    endcase
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("esc_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open esc_stimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h %h %h", op, a, b, c, d);
      if (n != 5) begin
        abort_run($sformatf("malformed stimulus line: %s", line));
      end
      recs.push_back({op, a, b, c, d});
    end
    $fclose(fd);
    if (recs.size() == 0) begin
      abort_run("stimulus file holds no records");
    end
  endtask

  // four quadrature steps per period, a leads b unless rev
  task automatic encoder_run(input int period, input int cycles, input logic rev, input logic en);
    int   q_clk;
    logic a_lvl;
    logic b_lvl;
    q_clk = period / 4 * tick_div;
    @(posedge clk);
    #2;
    for (int c = 0; c < cycles; c++) begin
      for (int s = 0; s < 4; s++) begin
        a_lvl     = (s == 1) || (s == 2);
        b_lvl     = (s >= 2);
        encoder_a = rev ? b_lvl : a_lvl;
        encoder_b = rev ? a_lvl : b_lvl;
        if (c == 0 && s == 1) pwm_en = en;  // enable arrives with the first edge
        repeat (q_clk) @(posedge clk);
        #2;
      end
    end
    encoder_a = 1'b0;
    encoder_b = 1'b0;
    pwm_en    = 1'b0;
    repeat (period * tick_div) @(posedge clk);  // idle period lets the bridge settle
  endtask

  task automatic random_readback(input int rounds);
    logic [axil_addr_w-1:0] addr;
    logic [axil_data_w-1:0] mask;
    logic [axil_data_w-1:0] got;
    logic [1:0]             resp;
    for (int r = 0; r < rounds; r++) begin
      for (int k = 0; k < 3; k++) begin
        addr      = (k == 0) ? reg_pwm_period : (k == 1) ? reg_period_ref : reg_gains;
        mask      = (k == 2) ? 32'h00ff_ffff : 32'h0000_ffff;  // unused bits read 0
        rng_state = xorshift32(rng_state);
        axi_write(addr, rng_state, resp);
        check_resp($sformatf("bresp @ %h", addr), resp, resp_okay);
        axi_read(addr, got, resp);
        check_resp($sformatf("rresp @ %h", addr), resp, resp_okay);
        check_data($sformatf("readback @ %h", addr), got, rng_state & mask);
      end
    end
  endtask

  task automatic run_record(input rec_t r);
    logic [axil_data_w-1:0] got;
    logic [1:0]             resp;
    motor_pair_t            seen;
    case (r.op)
      "W": begin
        axi_write(r.a[7:0], r.b, resp);
        check_resp($sformatf("bresp @ %h", r.a[7:0]), resp, r.c[1:0]);
      end
      "R": begin
        axi_read(r.a[7:0], got, resp);
        check_resp($sformatf("rresp @ %h", r.a[7:0]), resp, r.c[1:0]);
        check_data($sformatf("rdata @ %h", r.a[7:0]), got, r.b);
      end
      "X": random_readback(int'(r.a));
      "E": begin
        pos_base = pos_count;
        neg_base = neg_count;
        encoder_run(int'(r.a), int'(r.b), r.c[0], r.d[0]);
      end
      "M": begin
        seen.pos = (pos_count != pos_base);
        seen.neg = (neg_count != neg_base);
        check_motor("motor outputs", seen, {r.a[0], r.b[0]});
      end
      "T": repeat (int'(r.a) * tick_div) @(posedge clk);
      default: abort_run($sformatf("unknown stimulus opcode %c", r.op));
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // h-bridge activity, sampled before the edge updates it
  always @(posedge clk) begin
    if (!reset) begin
      if (motor_positive === 1'b1 && motor_negative === 1'b1) begin
        abort_run("both bridge outputs driven high at the same time");
      end
      if (motor_positive === 1'b1) pos_count <= pos_count + 1;
      if (motor_negative === 1'b1) neg_count <= neg_count + 1;
    end
  end

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout at %0t ns, the stimulus did not complete", $time);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    longint total;
    reset     = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    encoder_a = 1'b0;
    encoder_b = 1'b0;
    pwm_en    = 1'b0;
    load_stimulus();
    total = 10 * clk_period;  // reset and slack
    foreach (recs[i]) total += record_cost(recs[i]);
    limit_ns = total;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    foreach (recs[i]) run_record(recs[i]);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- esc_stimulus.txt
# op a b c d, all hex. W addr data resp, R addr data resp, X rounds,
# E period_ticks cycles rev pwm_en, M pos_seen neg_seen, T ticks. unused columns are 0
R 00 0 0 0
R 04 0 0 0
R 08 0 0 0
R 10 0 0 0
R 14 0 0 0
T 2 0 0 0
R 18 1 0 0
W 0c 1234 2 0
R 0c 0 2 0
X 4 0 0 0
W 08 0 0 0
W 00 10 0 0
W 04 14 0 0
E 18 4 0 0
M 0 0 0 0
R 10 18 0 0
E 10 4 0 1
M 1 0 0 0
R 10 10 0 0
E 10 4 1 1
M 0 1 0 0
W 00 40 0 0
W 04 8 0 0
T 2 0 0 0
R 14 40 0 0
W 04 200 0 0
T 2 0 0 0
R 14 10 0 0
W 08 800003 0 0
W 04 18 0 0
T 2 0 0 0
R 14 18 0 0
R 18 3 0 0
W 08 5 0 0
T 2 0 0 0
R 18 1 0 0
R 08 5 0 0

//--- verilog.f
+incdir+.
esc_pkg.sv
esc_axil_regs.sv
esc_input_sync.sv
esc_speed_meter.sv
esc_pid.sv
esc_pwm_drive.sv
esc_top.sv
tb_esc.sv
